// ==== rtl/frame_rd_pkg.sv ====
//----------------------------------------------------------------------
// frame read-back package
// widths, segment lengths, gap and FIFO sizes, state enums and the
// parser beat shared by the intake, parser and formatter
//----------------------------------------------------------------------
`default_nettype none

package frame_rd_pkg;

	// word widths
	localparam int WORD_W = 32;

	typedef logic [WORD_W-1:0] word_t;
	// top bit is the info flag
	typedef logic [WORD_W:0]   in_word_t;
	typedef logic [15:0]       size_t;
	typedef logic [1:0]        roi_idx_t;

	// segment sizes in 32-bit words
	localparam int ROI_NUM           = 4;
	localparam int LEADER_LEN        = 13;
	localparam int TRAILER_LEN_CHUNK = 9;
	localparam int TRAILER_LEN_PLAIN = 8;

	// gap before and after each frame, in cycles
	localparam int GAP_LEN   = 8;
	localparam int GAP_CNT_W = $clog2(GAP_LEN + 1);

	// intake FIFO
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

	typedef enum logic [1:0] {SEG_LEADER, SEG_IMAGE, SEG_CHUNK, SEG_TRAILER} seg_e;

	typedef enum logic [2:0] {PS_IDLE, PS_LEADER, PS_IMAGE, PS_CHUNK, PS_TRAILER} parse_state_e;

	typedef enum logic [1:0] {FS_IDLE, FS_LEAD_GAP, FS_ACTIVE, FS_TAIL_GAP} fmt_state_e;

	// one parser beat, 36 bits
	typedef struct packed {
		logic  valid;
		seg_e  seg;
		word_t data;
		// final trailer word of the frame
		logic  last;
	} beat_t;

endpackage

`default_nettype wire

// ==== rtl/word_intake.sv ====
//----------------------------------------------------------------------
// word intake
// four-phase req/ack receiver in front of a circular word FIFO,
// ack is withheld while the FIFO is full
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module word_intake
	import frame_rd_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     i_arst_n,
	// producer side
	input  wire logic     i_wr_req,
	input  wire in_word_t i_wr_word,
	output logic          o_wr_ack,
	// parser side
	input  wire logic     i_pop,
	output in_word_t      o_head,
	output logic          o_not_empty
);

	// pointers carry one wrap bit above the address
	logic [FIFO_AW:0] wr_ptr;
	logic [FIFO_AW:0] rd_ptr;
	in_word_t         mem [FIFO_DEPTH];
	logic             full;
	logic             push;
	logic             pop_ok;

	//------------------------------------------------------------------
	// FIFO status
	//------------------------------------------------------------------
	// full when addresses match and wrap bits differ
	assign full = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
	              (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
	assign o_not_empty = (wr_ptr != rd_ptr);

	// store on the req phase only, once per pulse
	assign push = i_wr_req && !o_wr_ack && !full;
	// guard against a pop on empty
	assign pop_ok = i_pop && o_not_empty;

	//------------------------------------------------------------------
	// handshake
	//------------------------------------------------------------------
	// ack follows req up after a store, and down once req drops
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_wr_ack <= 1'b0;
		end else if (push) begin
			o_wr_ack <= 1'b1;
		end else if (!i_wr_req) begin
			o_wr_ack <= 1'b0;
		end
	end

	//------------------------------------------------------------------
	// pointers and storage
	//------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
		end else if (push) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rd_ptr <= '0;
		end else if (pop_ok) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// word array
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr[FIFO_AW-1:0]] <= i_wr_word;
		end
	end

	// show-ahead head word
	assign o_head = mem[rd_ptr[FIFO_AW-1:0]];

endmodule

`default_nettype wire

// ==== rtl/frame_parser.sv ====
//----------------------------------------------------------------------
// frame parser
// splits the word stream into leader, image, chunk and trailer
// segments, picks the image size by ROI and emits one beat per word
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module frame_parser
	import frame_rd_pkg::*;
(
	input  wire logic                 clk,
	input  wire logic                 i_arst_n,
	input  wire logic                 i_stream_enable,
	// configuration
	input  wire size_t [ROI_NUM-1:0]  i_roi_sizes,
	input  wire size_t                i_chunk_len,
	// FIFO head
	input  wire in_word_t             i_head,
	input  wire logic                 i_not_empty,
	// from formatter
	input  wire logic                 i_grant,
	output logic                      o_pop,
	output beat_t                     o_beat
);

	parse_state_e state;
	parse_state_e state_nxt;
	size_t        word_cnt;
	size_t        seg_len;
	size_t        trailer_len;
	roi_idx_t     roi_idx;
	seg_e         cur_seg;
	logic         chunk_on;
	logic         info_flag;
	logic         data_pop;
	logic         seg_done;
	// beat register fields
	logic         beat_valid;
	seg_e         beat_seg;
	word_t        beat_data;
	logic         beat_last;

	//------------------------------------------------------------------
	// segment lengths
	//------------------------------------------------------------------
	// zero chunk length turns chunk mode off
	assign chunk_on    = (i_chunk_len != '0);
	assign trailer_len = chunk_on ? size_t'(TRAILER_LEN_CHUNK) : size_t'(TRAILER_LEN_PLAIN);

	always_comb begin
		case (state)
			PS_LEADER:  seg_len = size_t'(LEADER_LEN);
			PS_IMAGE:   seg_len = i_roi_sizes[roi_idx];
			PS_CHUNK:   seg_len = i_chunk_len;
			PS_TRAILER: seg_len = trailer_len;
			default:    seg_len = '0;
		endcase
	end

	// segment kind carried by the beat
	always_comb begin
		case (state)
			PS_IMAGE:   cur_seg = SEG_IMAGE;
			PS_CHUNK:   cur_seg = SEG_CHUNK;
			PS_TRAILER: cur_seg = SEG_TRAILER;
			default:    cur_seg = SEG_LEADER;
		endcase
	end

	//------------------------------------------------------------------
	// FIFO read
	//------------------------------------------------------------------
	assign info_flag = i_head[WORD_W];
	// read only inside a segment and while granted
	assign o_pop = i_stream_enable && i_grant && i_not_empty && (state != PS_IDLE);
	// flagged words are read and dropped
	assign data_pop = o_pop && !info_flag;
	assign seg_done = data_pop && (word_cnt == seg_len - 1'b1);

	//------------------------------------------------------------------
	// segment FSM
	//------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		if (!i_stream_enable) begin
			state_nxt = PS_IDLE;
		end else begin
			case (state)
				PS_IDLE: begin
					// frame starts with the grant
					if (i_grant) begin
						state_nxt = PS_LEADER;
					end
				end
				PS_LEADER: begin
					if (seg_done) begin
						state_nxt = PS_IMAGE;
					end
				end
				PS_IMAGE: begin
					if (seg_done) begin
						state_nxt = chunk_on ? PS_CHUNK : PS_TRAILER;
					end
				end
				PS_CHUNK: begin
					if (seg_done) begin
						state_nxt = PS_TRAILER;
					end
				end
				PS_TRAILER: begin
					if (seg_done) begin
						state_nxt = PS_IDLE;
					end
				end
				default: state_nxt = PS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= PS_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// one word counter shared by all segments
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			word_cnt <= '0;
		end else if (!i_stream_enable || state == PS_IDLE || seg_done) begin
			word_cnt <= '0;
		end else if (data_pop) begin
			word_cnt <= word_cnt + 1'b1;
		end
	end

	// info word at image position zero picks the ROI
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			roi_idx <= '0;
		end else if (o_pop && info_flag && state == PS_IMAGE && word_cnt == '0) begin
			roi_idx <= i_head[$bits(roi_idx_t)-1:0];
		end
	end

	//------------------------------------------------------------------
	// beat register
	//------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			beat_valid <= 1'b0;
			beat_seg   <= SEG_LEADER;
			beat_last  <= 1'b0;
		end else begin
			beat_valid <= data_pop;
			beat_last  <= seg_done && (state == PS_TRAILER);
			if (data_pop) begin
				beat_seg <= cur_seg;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (data_pop) begin
			beat_data <= i_head[WORD_W-1:0];
		end
	end

	assign o_beat = '{valid: beat_valid, seg: beat_seg, data: beat_data, last: beat_last};

endmodule

`default_nettype wire

// ==== rtl/stream_formatter.sv ====
//----------------------------------------------------------------------
// stream formatter
// frame gap timing, parser grant, fval and registered line strobes
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module stream_formatter
	import frame_rd_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  i_arst_n,
	input  wire logic  i_stream_enable,
	input  wire logic  i_not_empty,
	input  wire beat_t i_beat,
	output logic       o_grant,
	output logic       o_fval,
	output logic       o_lval,
	output logic       o_lval_leader,
	output logic       o_lval_chunk,
	output logic       o_lval_trailer,
	output word_t      o_pix_data
);

	fmt_state_e           state;
	logic [GAP_CNT_W-1:0] gap_cnt;
	logic                 gap_end;
	logic                 beat_ok;

	assign gap_end = (gap_cnt == GAP_CNT_W'(GAP_LEN - 1));
	// drops with the last beat, before the FSM leaves active
	assign o_grant = (state == FS_ACTIVE) && !i_beat.last;
	assign beat_ok = i_stream_enable && i_beat.valid;

	//------------------------------------------------------------------
	// gap FSM and fval
	//------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state   <= FS_IDLE;
			gap_cnt <= '0;
			o_fval  <= 1'b0;
		end else if (!i_stream_enable) begin
			state   <= FS_IDLE;
			gap_cnt <= '0;
			o_fval  <= 1'b0;
		end else begin
			case (state)
				FS_IDLE: begin
					// first buffered word starts the frame
					gap_cnt <= '0;
					if (i_not_empty) begin
						state <= FS_LEAD_GAP;
					end
				end
				FS_LEAD_GAP: begin
					gap_cnt <= gap_cnt + 1'b1;
					if (gap_end) begin
						state  <= FS_ACTIVE;
						o_fval <= 1'b1;
					end
				end
				FS_ACTIVE: begin
					gap_cnt <= '0;
					if (i_beat.valid && i_beat.last) begin
						state <= FS_TAIL_GAP;
					end
				end
				FS_TAIL_GAP: begin
					gap_cnt <= gap_cnt + 1'b1;
					if (gap_end) begin
						state  <= FS_IDLE;
						o_fval <= 1'b0;
					end
				end
				default: state <= FS_IDLE;
			endcase
		end
	end

	//------------------------------------------------------------------
	// output strobes and data
	//------------------------------------------------------------------
	// one strobe per segment kind
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_lval         <= 1'b0;
			o_lval_leader  <= 1'b0;
			o_lval_chunk   <= 1'b0;
			o_lval_trailer <= 1'b0;
		end else begin
			o_lval         <= beat_ok && (i_beat.seg == SEG_IMAGE);
			o_lval_leader  <= beat_ok && (i_beat.seg == SEG_LEADER);
			o_lval_chunk   <= beat_ok && (i_beat.seg == SEG_CHUNK);
			o_lval_trailer <= beat_ok && (i_beat.seg == SEG_TRAILER);
		end
	end

	// data holds between strobes
	always_ff @(posedge clk) begin
		if (beat_ok) begin
			o_pix_data <= i_beat.data;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/frame_readback_top.sv ====
//----------------------------------------------------------------------
// frame read-back top
// word intake, frame parser and stream formatter joined together
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module frame_readback_top
	import frame_rd_pkg::*;
(
	input  wire logic                clk,
	input  wire logic                i_arst_n,
	input  wire logic                i_stream_enable,
	// configuration
	input  wire size_t [ROI_NUM-1:0] i_roi_sizes,
	input  wire size_t               i_chunk_len,
	// producer handshake
	input  wire logic                i_wr_req,
	input  wire in_word_t            i_wr_word,
	output logic                     o_wr_ack,
	// video-style output
	output logic                     o_fval,
	output logic                     o_lval,
	output logic                     o_lval_leader,
	output logic                     o_lval_chunk,
	output logic                     o_lval_trailer,
	output word_t                    o_pix_data
);

	in_word_t head;
	logic     not_empty;
	logic     pop;
	logic     grant;
	beat_t    beat;

	word_intake u_intake (
		.clk         (clk),
		.i_arst_n    (i_arst_n),
		.i_wr_req    (i_wr_req),
		.i_wr_word   (i_wr_word),
		.o_wr_ack    (o_wr_ack),
		.i_pop       (pop),
		.o_head      (head),
		.o_not_empty (not_empty)
	);

	frame_parser u_parser (
		.clk             (clk),
		.i_arst_n        (i_arst_n),
		.i_stream_enable (i_stream_enable),
		.i_roi_sizes     (i_roi_sizes),
		.i_chunk_len     (i_chunk_len),
		.i_head          (head),
		.i_not_empty     (not_empty),
		.i_grant         (grant),
		.o_pop           (pop),
		.o_beat          (beat)
	);

	stream_formatter u_formatter (
		.clk             (clk),
		.i_arst_n        (i_arst_n),
		.i_stream_enable (i_stream_enable),
		.i_not_empty     (not_empty),
		.i_beat          (beat),
		.o_grant         (grant),
		.o_fval          (o_fval),
		.o_lval          (o_lval),
		.o_lval_leader   (o_lval_leader),
		.o_lval_chunk    (o_lval_chunk),
		.o_lval_trailer  (o_lval_trailer),
		.o_pix_data      (o_pix_data)
	);

endmodule

`default_nettype wire

// ==== dv/frame_readback_props.sv ====
//----------------------------------------------------------------------
// frame read-back properties
// handshake rules on the producer side and strobe rules on the
// video-style output, bound to the top level
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module frame_readback_props (
	input wire logic clk,
	input wire logic i_arst_n,
	input wire logic i_wr_req,
	input wire logic o_wr_ack,
	input wire logic o_fval,
	input wire logic o_lval,
	input wire logic o_lval_leader,
	input wire logic o_lval_chunk,
	input wire logic o_lval_trailer
);

	logic [3:0] strobes;

	assign strobes = {o_lval_leader, o_lval, o_lval_chunk, o_lval_trailer};

	// ack goes up only in answer to a raised req
	ack_after_req: assert property (@(posedge clk) disable iff (!i_arst_n)
		$rose(o_wr_ack) |-> $past(i_wr_req))
		else $error("ack rose without req");

	// producer holds req until the word is taken
	req_held: assert property (@(posedge clk) disable iff (!i_arst_n)
		(i_wr_req && !o_wr_ack) |=> i_wr_req)
		else $error("req dropped before ack");

	strobe_onehot: assert property (@(posedge clk) disable iff (!i_arst_n)
		$onehot0(strobes))
		else $error("more than one line strobe high");

	// strobes only inside the frame window
	strobe_in_fval: assert property (@(posedge clk) disable iff (!i_arst_n)
		(|strobes) |-> o_fval)
		else $error("line strobe high while fval low");

endmodule

bind frame_readback_top frame_readback_props u_props (
	.clk            (clk),
	.i_arst_n       (i_arst_n),
	.i_wr_req       (i_wr_req),
	.o_wr_ack       (o_wr_ack),
	.o_fval         (o_fval),
	.o_lval         (o_lval),
	.o_lval_leader  (o_lval_leader),
	.o_lval_chunk   (o_lval_chunk),
	.o_lval_trailer (o_lval_trailer)
);

`default_nettype wire

// ==== dv/tb_frame_readback.sv ====
//----------------------------------------------------------------------
// frame read-back testbench
// file-driven four-phase producer, output monitor with in-order
// word and class checks, per-frame segment counts and gap timing
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_frame_readback
	import frame_rd_pkg::*;
;

	localparam int N_FRAMES  = 4;
	localparam int MEM_DEPTH = 256;
	localparam int CLS_DROP  = 4;

	logic                 clk;
	logic                 i_arst_n;
	logic                 i_stream_enable;
	size_t [ROI_NUM-1:0]  i_roi_sizes;
	size_t                i_chunk_len;
	logic                 i_wr_req;
	in_word_t             i_wr_word;
	logic                 o_wr_ack;
	logic                 o_fval;
	logic                 o_lval;
	logic                 o_lval_leader;
	logic                 o_lval_chunk;
	logic                 o_lval_trailer;
	word_t                o_pix_data;

	// file entry: bit 36 flag, 35:4 data, 3:0 class
	logic [39:0]          stim_mem [MEM_DEPTH];
	int                   frame_base [N_FRAMES];
	int                   frame_words [N_FRAMES];
	int                   frame_pause [N_FRAMES];
	size_t                frame_chunk [N_FRAMES];
	size_t [ROI_NUM-1:0]  frame_roi [N_FRAMES];
	// per-frame strobe counts worked out from the segment rules
	int                   rule_cnt [N_FRAMES][4];
	int                   rule_total [N_FRAMES];
	logic [35:0]          exp_q [$];

	int                   err_cnt;
	int                   cycle;
	int                   limit;
	int                   rx_cnt;
	int                   got_cnt [4];
	int                   frame_rx;
	int                   frame_err0;
	int                   fval_falls;
	int                   last_strobe;
	int                   wait_run;
	logic                 stall_seen;
	logic                 fval_q;
	logic                 en_q;

	frame_readback_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//------------------------------------------------------------------
	// stimulus file
	//------------------------------------------------------------------
	task automatic load_stimulus();
		int         idx;
		int         listed;
		logic [39:0] e;
		$readmemh("dv/frame_stimulus.txt", stim_mem);
		idx   = 0;
		limit = 0;
		for (int f = 0; f < N_FRAMES; f++) begin
			frame_words[f] = int'(stim_mem[idx][39:32]);
			frame_chunk[f] = stim_mem[idx][31:16];
			frame_pause[f] = int'(stim_mem[idx][15:0]);
			frame_roi[f]   = {stim_mem[idx+2][31:0], stim_mem[idx+1][31:0]};
			frame_base[f]  = idx + 3;
			idx            = idx + 3 + frame_words[f];
			// info word right after the leader picks the ROI
			e = stim_mem[frame_base[f] + LEADER_LEN];
			assert (e[36]) else begin
				$display("frame %0d has no info word after the leader", f);
				err_cnt++;
			end
			rule_cnt[f][0] = LEADER_LEN;
			rule_cnt[f][1] = int'(frame_roi[f][e[5:4]]);
			rule_cnt[f][2] = int'(frame_chunk[f]);
			rule_cnt[f][3] = (frame_chunk[f] != '0) ? TRAILER_LEN_CHUNK : TRAILER_LEN_PLAIN;
			rule_total[f]  = rule_cnt[f][0] + rule_cnt[f][1] + rule_cnt[f][2] + rule_cnt[f][3];
			listed = 0;
			for (int w = 0; w < frame_words[f]; w++) begin
				e = stim_mem[frame_base[f] + w];
				if (e[3:0] != CLS_DROP) begin
					exp_q.push_back(e[35:0]);
					listed++;
				end
			end
			assert (listed == rule_total[f]) else begin
				$display("frame %0d lists %0d output words but the rules give %0d",
				         f, listed, rule_total[f]);
				err_cnt++;
			end
			// 4-cycle handshake plus random gaps, frame gaps and pauses
			limit += 8 * frame_words[f] + 2 * GAP_LEN + 8 + frame_pause[f];
		end
	endtask

	//------------------------------------------------------------------
	// producer
	//------------------------------------------------------------------
	task automatic send_word(input logic [39:0] e);
		int gap;
		gap = $urandom % 3;
		repeat (gap) @(posedge clk);
		i_wr_word <= e[36:4];
		i_wr_req  <= 1'b1;
		@(posedge clk);
		while (!o_wr_ack) @(posedge clk);
		i_wr_req <= 1'b0;
		@(posedge clk);
		while (o_wr_ack) @(posedge clk);
	endtask

	initial begin
		void'($urandom(63481));
		err_cnt     = 0;
		i_arst_n    = 1'b0;
		i_wr_req    = 1'b0;
		i_wr_word   = '0;
		load_stimulus();
		i_roi_sizes = frame_roi[0];
		i_chunk_len = frame_chunk[0];
		repeat (2) @(posedge clk);
		i_arst_n <= 1'b1;
		for (int f = 0; f < N_FRAMES; f++) begin
			// paused frames start only once the stream is held off
			if (frame_pause[f] > 0) begin
				while (fval_falls < f || i_stream_enable) @(posedge clk);
			end
			for (int w = 0; w < frame_words[f]; w++) begin
				send_word(stim_mem[frame_base[f] + w]);
			end
		end
		while (frame_rx < N_FRAMES || o_fval) @(posedge clk);
		assert (exp_q.size() == 0) else begin
			$display("%0d expected words never came out", exp_q.size());
			err_cnt++;
		end
		assert (stall_seen) else begin
			$display("the FIFO never filled, so ack was never held back");
			err_cnt++;
		end
		$display("frames %0d of %0d, errors %0d", frame_rx, N_FRAMES, err_cnt);
		if (err_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// stream enable held low between frames for paused frames
	initial begin
		i_stream_enable = 1'b1;
		@(posedge i_arst_n);
		for (int f = 1; f < N_FRAMES; f++) begin
			if (frame_pause[f] > 0) begin
				while (fval_falls < f) @(posedge clk);
				i_stream_enable <= 1'b0;
				repeat (frame_pause[f]) @(posedge clk);
				i_stream_enable <= 1'b1;
			end
		end
	end

	//------------------------------------------------------------------
	// monitor
	//------------------------------------------------------------------
	task automatic check_strobe();
		int          cls;
		logic [35:0] e;
		cls = o_lval_leader ? 0 : (o_lval ? 1 : (o_lval_chunk ? 2 : 3));
		assert (o_fval) else begin
			$display("strobe seen while fval is low");
			err_cnt++;
		end
		if (rx_cnt == 0 && frame_rx > 0) begin
			assert (cycle - last_strobe >= 2 * GAP_LEN) else begin
				$display("frame gap of %0d cycles is too short", cycle - last_strobe);
				err_cnt++;
			end
			// fval drops once between two frames
			assert (fval_falls == frame_rx) else begin
				$display("fval did not drop before frame %0d started", frame_rx);
				err_cnt++;
			end
		end
		assert (exp_q.size() != 0 && frame_rx < N_FRAMES) else begin
			$display("strobe seen with no expected word left");
			err_cnt++;
		end
		if (exp_q.size() != 0 && frame_rx < N_FRAMES) begin
			e = exp_q.pop_front();
			assert (cls == int'(e[3:0])) else begin
				$display("error: strobe class got %h expected %h", cls, e[3:0]);
				err_cnt++;
			end
			assert (o_pix_data == e[35:4]) else begin
				$display("error: o_pix_data got %h expected %h", o_pix_data, e[35:4]);
				err_cnt++;
			end
			got_cnt[cls]++;
			rx_cnt++;
			if (rx_cnt == rule_total[frame_rx]) begin
				for (int c = 0; c < 4; c++) begin
					assert (got_cnt[c] == rule_cnt[frame_rx][c]) else begin
						$display("error: class %0d strobe count got %h expected %h",
						         c, got_cnt[c], rule_cnt[frame_rx][c]);
						err_cnt++;
					end
					got_cnt[c] = 0;
				end
				$display("frame %0d: %0d words, %0d errors", frame_rx, rx_cnt,
				         err_cnt - frame_err0);
				frame_err0 = err_cnt;
				frame_rx++;
				rx_cnt = 0;
			end
		end
		last_strobe = cycle;
	endtask

	always @(posedge clk) begin
		if (i_arst_n) begin
			if (o_lval || o_lval_leader || o_lval_chunk || o_lval_trailer) begin
				check_strobe();
			end
			// held-off stream stays dark
			if (!en_q && !i_stream_enable) begin
				assert (!o_fval && !o_lval && !o_lval_leader && !o_lval_chunk &&
				        !o_lval_trailer) else begin
					$display("output active while the stream is disabled");
					err_cnt++;
				end
			end
			// next frame's configuration once fval drops
			if (fval_q && !o_fval) begin
				fval_falls++;
				if (fval_falls < N_FRAMES) begin
					i_roi_sizes <= frame_roi[fval_falls];
					i_chunk_len <= frame_chunk[fval_falls];
				end
			end
			wait_run   = (i_wr_req && !o_wr_ack) ? wait_run + 1 : 0;
			stall_seen = stall_seen || (wait_run > 2);
		end
		fval_q = o_fval;
		en_q   = i_stream_enable;
	end

	// run limit
	always @(posedge clk) begin
		cycle++;
		if (cycle >= limit) begin
			$display("timeout after %0d cycles with %0d frames out", cycle, frame_rx);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		cycle       = 0;
		rx_cnt      = 0;
		frame_rx    = 0;
		frame_err0  = 0;
		fval_falls  = 0;
		last_strobe = 0;
		wait_run    = 0;
		stall_seen  = 1'b0;
		fval_q      = 1'b0;
		en_q        = 1'b1;
		for (int c = 0; c < 4; c++) begin
			got_cnt[c] = 0;
		end
	end

endmodule

`default_nettype wire

// ==== dv/frame_stimulus.txt ====
// per frame: {count, chunk_len, pause} then {roi1, roi0} then {roi3, roi2}
// then words {flag, data, class}, class 0 leader 1 image 2 chunk 3 trailer 4 dropped
1c_0000_0000 0006_0004 0005_0003
a000 a010 a020 a030 a040 a050 a060 a070 a080 a090 a0a0 a0b0 a0c0
1_0000_0001_4 b001 b011 b021 b031 b041 b051
d003 d013 d023 d033 d043 d053 d063 d073
1d_0002_0000 0006_0004 0005_0003
1a000 1a010 1a020 1a030 1a040 1a050 1a060 1a070 1a080 1a090 1a0a0 1a0b0 1a0c0
1_0000_0002_4 1b001 1b011 1_0000_00ee_4 1b021 1c002 1c012
1d003 1d013 1d023 1d033 1d043 1d053 1d063 1d073 1d083
18_0000_00a0 0005_0002 0003_0004
2a000 2a010 2a020 2a030 2a040 2a050 2a060 2a070 2a080 2a090 2a0a0 2a0b0 2a0c0
1_0000_0000_4 2b001 2b011
2d003 2d013 2d023 2d033 2d043 2d053 2d063 2d073
1d_0003_0000 0005_0002 0003_0004
3a000 3a010 3a020 3a030 3a040 3a050 3a060 3a070 3a080 3a090 3a0a0 3a0b0 3a0c0
1_0000_0003_4 3b001 3b011 3b021 3c002 3c012 3c022
3d003 3d013 3d023 3d033 3d043 3d053 3d063 3d073 3d083

// ==== project.f ====
rtl/frame_rd_pkg.sv
rtl/word_intake.sv
rtl/frame_parser.sv
rtl/stream_formatter.sv
rtl/frame_readback_top.sv
dv/frame_readback_props.sv
dv/tb_frame_readback.sv

// ==== Bender.yml ====
package:
  name: frame_readback

sources:
  - rtl/frame_rd_pkg.sv
  - rtl/word_intake.sv
  - rtl/frame_parser.sv
  - rtl/stream_formatter.sv
  - rtl/frame_readback_top.sv
  - target: simulation
    files:
      - dv/frame_readback_props.sv
      - dv/tb_frame_readback.sv
